// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_conv_engine
FILELIST  ?= conv_engine.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: conv_engine.f
rtl/conv_pkg.sv
rtl/burst_deser.sv
rtl/mac_array.sv
rtl/line_accum.sv
rtl/conv_addr_gen.sv
rtl/conv_ctrl.sv
rtl/conv_engine.sv
test/conv_engine_props.sv
test/tb_conv_engine.sv

// File: rtl/burst_deser.sv
`timescale 1ns/1ns
module burst_deser #(
	parameter int DEPTH = 16
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       i_clear,
	input  logic                       i_we,
	input  conv_pkg::word_t            i_word,
	input  logic [conv_pkg::CH_W-1:0]  i_len,
	input  logic [$clog2(DEPTH)-1:0]   i_base,
	output conv_pkg::word_t [DEPTH-1:0] o_buf,
	output logic                       o_full
);
	import conv_pkg::*;

	localparam int AW = $clog2(DEPTH);

	logic [CH_W-1:0] cnt;                        // Words of the current burst
	logic [AW-1:0] idx;

	assign idx = i_base + AW'(cnt);

	// Buffer write, clear zeroes unused lanes
	always_ff @(posedge clk) begin
		if (i_clear)
			o_buf <= '0;
		else if (i_we)
			o_buf[idx] <= i_word;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
			o_full <= 1'b0;
		end else begin
			o_full <= 1'b0;                      // Single-cycle flag
			if (i_clear) begin
				cnt <= '0;
			end else if (i_we) begin
				if (cnt + 1'b1 == i_len) begin   // Last word of the burst
					cnt <= '0;
					o_full <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/conv_addr_gen.sv
`timescale 1ns/1ns
module conv_addr_gen (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [conv_pkg::ADDR_W-1:0] i_data_addr,
	input  logic [conv_pkg::ADDR_W-1:0] i_weight_addr,
	input  logic [conv_pkg::ADDR_W-1:0] i_result_addr,
	input  logic [conv_pkg::CNT_W-1:0]  i_kernel,
	input  logic [conv_pkg::CNT_W-1:0]  i_stride,
	input  logic [conv_pkg::CNT_W-1:0]  i_i_side,
	input  logic [conv_pkg::CNT_W-1:0]  i_o_side,
	input  logic [conv_pkg::CH_W-1:0]   i_i_channel,
	input  logic [conv_pkg::CH_W-1:0]   i_oc,
	input  logic [conv_pkg::CH_W-1:0]   i_group_base,
	input  logic [conv_pkg::CNT_W-1:0]  i_row,
	input  logic [conv_pkg::CNT_W-1:0]  i_col,
	input  logic [conv_pkg::CNT_W-1:0]  i_kr,
	input  logic [conv_pkg::CNT_W-1:0]  i_kc,
	output logic [conv_pkg::ADDR_W-1:0] o_data_rd_addr,
	output logic [conv_pkg::ADDR_W-1:0] o_wt_rd_addr,
	output logic [conv_pkg::ADDR_W-1:0] o_wr_addr
);
	import conv_pkg::*;

	logic [ADDR_W-1:0] in_row;                   // Input pixel under this tap
	logic [ADDR_W-1:0] in_col;
	logic [ADDR_W-1:0] in_pix;
	logic [ADDR_W-1:0] wt_tap;                   // Tap index over oc, kr, kc
	logic [ADDR_W-1:0] out_pix;

	always_comb begin
		in_row = i_row * i_stride + i_kr;
		in_col = i_col * i_stride + i_kc;
		in_pix = in_row * i_i_side + in_col;
		wt_tap = (i_oc * i_kernel + i_kr) * i_kernel + i_kc;
		out_pix = (i_oc * i_o_side + i_row) * i_o_side + i_col;
	end

	// One cycle behind the counters
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_data_rd_addr <= '0;
			o_wt_rd_addr <= '0;
			o_wr_addr <= '0;
		end else begin
			o_data_rd_addr <= i_data_addr + in_pix * i_i_channel + i_group_base;
			o_wt_rd_addr <= i_weight_addr + wt_tap * i_i_channel + i_group_base;
			o_wr_addr <= i_result_addr + out_pix;  // Channel-major result plane
		end
	end

endmodule

// File: rtl/conv_ctrl.sv
`timescale 1ns/1ns
module conv_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_start,
	input  logic [conv_pkg::CNT_W-1:0]  i_kernel,
	input  logic [conv_pkg::CH_W-1:0]   i_i_channel,
	input  logic [conv_pkg::CH_W-1:0]   i_o_channel,
	input  logic [conv_pkg::CNT_W-1:0]  i_o_side,
	input  logic                        i_data_full,
	input  logic                        i_wt_full,
	input  logic                        i_mac_done,
	input  logic                        i_accum_busy,
	output logic                        o_done,
	output logic                        o_data_rd,
	output logic                        o_wt_rd,
	output logic [conv_pkg::CH_W-1:0]   o_oc,
	output logic [conv_pkg::CNT_W-1:0]  o_row,
	output logic [conv_pkg::CNT_W-1:0]  o_col,
	output logic [conv_pkg::CNT_W-1:0]  o_kr,
	output logic [conv_pkg::CNT_W-1:0]  o_kc,
	output logic [conv_pkg::CH_W-1:0]   o_group_base,
	output logic [conv_pkg::CH_W-1:0]   o_para,
	output logic [conv_pkg::TAP_W-1:0]  o_tap,
	output logic [conv_pkg::WT_AW-1:0]  o_wt_base,
	output logic                        o_atom_valid,
	output logic                        o_first_tap,
	output logic                        o_last_tap,
	output logic                        o_first_group,
	output logic                        o_last_group
);
	import conv_pkg::*;

	state_t state;
	logic [CNT_W-1:0] kernel;                    // Sampled at start
	logic [CNT_W-1:0] o_side;
	logic [CH_W-1:0] i_ch;
	logic [CH_W-1:0] o_ch;
	logic req;                                   // Read pulse due next cycle
	logic [CH_W-1:0] remain;                     // Channels left from this group on
	logic tap_adv;
	logic tap_end;
	logic kc_end;
	logic col_end;
	logic row_end;
	logic oc_end;

	assign remain = i_ch - o_group_base;
	assign o_para = (remain > CH_W'(PARA)) ? CH_W'(PARA) : remain;
	assign kc_end = (o_kc == kernel - 1'b1);
	assign tap_end = kc_end && (o_kr == kernel - 1'b1);
	assign col_end = (o_col == o_side - 1'b1);
	assign row_end = (o_row == o_side - 1'b1);
	assign oc_end = (o_oc == o_ch - 1'b1);
	assign o_first_group = (o_group_base == '0);
	assign o_last_group = (remain <= CH_W'(PARA));
	assign o_first_tap = (o_tap == '0);
	assign o_last_tap = tap_end;
	assign o_atom_valid = (state == ST_FETCH) && i_data_full;  // MAC takes the atom now
	assign o_wt_base = WT_AW'(o_tap * PARA);    // Weight slot of this tap

	// Tap walk is shared by weight loading and data fetching
	assign tap_adv = ((state == ST_LOAD_WT) && i_wt_full) || o_atom_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_kr <= '0;
			o_kc <= '0;
			o_tap <= '0;
		end else if (tap_adv) begin
			if (tap_end) begin                   // Back to the first tap
				o_kr <= '0;
				o_kc <= '0;
				o_tap <= '0;
			end else begin
				o_kc <= kc_end ? '0 : o_kc + 1'b1;
				o_kr <= kc_end ? o_kr + 1'b1 : o_kr;
				o_tap <= o_tap + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
			o_done <= 1'b0;
			o_data_rd <= 1'b0;
			o_wt_rd <= 1'b0;
			req <= 1'b0;
			kernel <= '0;
			o_side <= '0;
			i_ch <= '0;
			o_ch <= '0;
			o_oc <= '0;
			o_row <= '0;
			o_col <= '0;
			o_group_base <= '0;
		end else begin
			o_data_rd <= 1'b0;
			o_wt_rd <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						kernel <= i_kernel;
						o_side <= i_o_side;
						i_ch <= i_i_channel;
						o_ch <= i_o_channel;
						o_oc <= '0;
						o_row <= '0;
						o_col <= '0;
						o_group_base <= '0;
						o_done <= 1'b0;
						req <= 1'b1;
						state <= ST_LOAD_WT;
					end
				end
				ST_LOAD_WT: begin
					if (req) begin           // Address has settled by now
						o_wt_rd <= 1'b1;
						req <= 1'b0;
					end
					if (i_wt_full) begin
						req <= 1'b1;
						if (tap_end)
							state <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					if (req) begin
						o_data_rd <= 1'b1;
						req <= 1'b0;
					end
					if (i_data_full) begin
						if (tap_end)
							state <= ST_WAIT_PIX;  // All taps in flight
						else
							req <= 1'b1;
					end
				end
				ST_WAIT_PIX: begin
					if (i_mac_done)
						state <= ST_STEP;
				end
				ST_STEP: begin
					if (!i_accum_busy) begin     // Hold while a result is written
						req <= 1'b1;
						if (!col_end) begin
							o_col <= o_col + 1'b1;
							state <= ST_FETCH;
						end else begin
							o_col <= '0;
							state <= ST_LOAD_WT;     // New group reloads weights
							if (!o_last_group) begin
								o_group_base <= o_group_base + CH_W'(PARA);
							end else begin
								o_group_base <= '0;
								if (!row_end) begin
									o_row <= o_row + 1'b1;
								end else begin
									o_row <= '0;
									if (!oc_end) begin
										o_oc <= o_oc + 1'b1;
									end else begin
										req <= 1'b0;
										state <= ST_FINISH;
									end
								end
							end
						end
					end
				end
				ST_FINISH: begin
					if (!i_accum_busy) begin     // Last write has completed
						o_done <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/conv_engine.sv
`timescale 1ns/1ns
module conv_engine #(
	parameter int LANES = conv_pkg::PARA,
	parameter int SIDE = conv_pkg::MAX_SIDE,
	parameter int TAPS = conv_pkg::TAPS
) (
	input  logic                        clk,
	input  logic                        rst,
	// Layer control
	input  logic                        i_start,
	output logic                        o_done,
	input  logic [conv_pkg::CNT_W-1:0]  i_kernel,
	input  logic [conv_pkg::CNT_W-1:0]  i_stride,
	input  logic [conv_pkg::CH_W-1:0]   i_i_channel,
	input  logic [conv_pkg::CH_W-1:0]   i_o_channel,
	input  logic [conv_pkg::CNT_W-1:0]  i_i_side,
	input  logic [conv_pkg::CNT_W-1:0]  i_o_side,
	input  logic [conv_pkg::ADDR_W-1:0] i_data_addr,
	input  logic [conv_pkg::ADDR_W-1:0] i_weight_addr,
	input  logic [conv_pkg::ADDR_W-1:0] i_result_addr,
	// DMA data read port
	output logic                        o_data_rd_en,
	output logic [conv_pkg::ADDR_W-1:0] o_data_rd_addr,
	input  conv_pkg::word_t             i_data,
	input  logic                        i_data_we,
	// DMA weight read port
	output logic                        o_wt_rd_en,
	output logic [conv_pkg::ADDR_W-1:0] o_wt_rd_addr,
	input  conv_pkg::word_t             i_wt,
	input  logic                        i_wt_we,
	// DMA write port
	output logic                        o_wr_en,
	output logic [conv_pkg::ADDR_W-1:0] o_wr_addr,
	input  logic                        i_wr_re,
	output logic                        o_wr_valid,
	output conv_pkg::word_t             o_wr_data
);
	import conv_pkg::*;

	// Loop counters from the controller
	logic [CH_W-1:0] oc;
	logic [CH_W-1:0] group_base;
	logic [CH_W-1:0] para;                       // Words per burst in this group
	logic [CNT_W-1:0] row;
	logic [CNT_W-1:0] col;
	logic [CNT_W-1:0] kr;
	logic [CNT_W-1:0] kc;
	logic [TAP_W-1:0] tap;
	logic [WT_AW-1:0] wt_base;
	logic atom_valid;
	logic first_tap;
	logic last_tap;
	logic first_group;
	logic last_group;
	logic data_full;
	logic wt_full;
	logic mac_valid;
	logic accum_busy;
	word_t psum;
	word_t [LANES-1:0] data_buf;
	word_t [LANES*TAPS-1:0] wt_buf;
	logic [ADDR_W-1:0] wr_addr;                  // Result address of current pixel

	conv_ctrl u_ctrl (
		.clk(clk), .rst(rst), .i_start(i_start),
		.i_kernel(i_kernel), .i_i_channel(i_i_channel), .i_o_channel(i_o_channel),
		.i_o_side(i_o_side), .i_data_full(data_full), .i_wt_full(wt_full),
		.i_mac_done(mac_valid), .i_accum_busy(accum_busy),
		.o_done(o_done), .o_data_rd(o_data_rd_en), .o_wt_rd(o_wt_rd_en),
		.o_oc(oc), .o_row(row), .o_col(col), .o_kr(kr), .o_kc(kc),
		.o_group_base(group_base), .o_para(para), .o_tap(tap), .o_wt_base(wt_base),
		.o_atom_valid(atom_valid), .o_first_tap(first_tap), .o_last_tap(last_tap),
		.o_first_group(first_group), .o_last_group(last_group)
	);

	conv_addr_gen u_addr_gen (
		.clk(clk), .rst(rst),
		.i_data_addr(i_data_addr), .i_weight_addr(i_weight_addr),
		.i_result_addr(i_result_addr), .i_kernel(i_kernel), .i_stride(i_stride),
		.i_i_side(i_i_side), .i_o_side(i_o_side), .i_i_channel(i_i_channel),
		.i_oc(oc), .i_group_base(group_base), .i_row(row), .i_col(col),
		.i_kr(kr), .i_kc(kc),
		.o_data_rd_addr(o_data_rd_addr), .o_wt_rd_addr(o_wt_rd_addr), .o_wr_addr(wr_addr)
	);

	// Data atom, cleared on every read so lanes past para stay zero
	burst_deser #(.DEPTH(LANES)) u_data_deser (
		.clk(clk), .rst(rst), .i_clear(o_data_rd_en), .i_we(i_data_we),
		.i_word(i_data), .i_len(para), .i_base('0),
		.o_buf(data_buf), .o_full(data_full)
	);

	// Stale weight lanes only ever meet zero data lanes
	burst_deser #(.DEPTH(LANES*TAPS)) u_wt_deser (
		.clk(clk), .rst(rst), .i_clear(1'b0), .i_we(i_wt_we),
		.i_word(i_wt), .i_len(para), .i_base(wt_base),
		.o_buf(wt_buf), .o_full(wt_full)
	);

	mac_array #(.LANES(LANES), .TAPS(TAPS)) u_mac (
		.clk(clk), .rst(rst), .i_valid(atom_valid), .i_first(first_tap),
		.i_last(last_tap), .i_data_atom(data_buf), .i_wt_buf(wt_buf), .i_tap(tap),
		.o_psum(psum), .o_valid(mac_valid)
	);

	line_accum #(.SIDE(SIDE)) u_accum (
		.clk(clk), .rst(rst), .i_valid(mac_valid), .i_psum(psum), .i_col(col),
		.i_first_group(first_group), .i_last_group(last_group),
		.i_wr_addr(wr_addr), .i_wr_re(i_wr_re), .o_busy(accum_busy),
		.o_wr_en(o_wr_en), .o_wr_addr(o_wr_addr), .o_wr_valid(o_wr_valid),
		.o_wr_data(o_wr_data)
	);

endmodule

// File: rtl/conv_pkg.sv
package conv_pkg;

	localparam int DATA_W = 16;                  // Data, weight and sum words
	localparam int ADDR_W = 30;                  // DMA word address
	localparam int PARA = 16;                    // MAC lanes, max channels per group
	localparam int MAX_K = 3;                    // Largest kernel side
	localparam int MAX_SIDE = 128;               // Largest output side
	localparam int CNT_W = 8;                    // Side, kernel and stride counters
	localparam int CH_W = 16;                    // Channel counts

	// Derived sizes of the weight buffer
	localparam int TAPS = MAX_K * MAX_K;
	localparam int TAP_W = $clog2(TAPS);
	localparam int WT_DEPTH = PARA * TAPS;       // One atom per tap
	localparam int WT_AW = $clog2(WT_DEPTH);

	typedef logic [DATA_W-1:0] word_t;

	// Layer FSM
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD_WT,                              // K*K weight atoms of a group
		ST_FETCH,                                // One data atom per tap
		ST_WAIT_PIX,                             // MAC pipeline drains
		ST_STEP,                                 // Next column, group, row, oc
		ST_FINISH
	} state_t;

endpackage

// File: rtl/line_accum.sv
`timescale 1ns/1ns
module line_accum #(
	parameter int SIDE = 128
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_valid,
	input  conv_pkg::word_t             i_psum,
	input  logic [conv_pkg::CNT_W-1:0]  i_col,
	input  logic                        i_first_group,
	input  logic                        i_last_group,
	input  logic [conv_pkg::ADDR_W-1:0] i_wr_addr,
	input  logic                        i_wr_re,
	output logic                        o_busy,
	output logic                        o_wr_en,
	output logic [conv_pkg::ADDR_W-1:0] o_wr_addr,
	output logic                        o_wr_valid,
	output conv_pkg::word_t             o_wr_data
);
	import conv_pkg::*;

	localparam int AW = $clog2(SIDE);

	word_t sum_buf [SIDE];                       // One running sum per output column
	word_t total;
	logic [AW-1:0] slot;

	assign slot = i_col[AW-1:0];
	// First group overwrites the stale row
	assign total = i_first_group ? i_psum : sum_buf[slot] + i_psum;
	assign o_busy = o_wr_en | o_wr_valid;       // Write sequence in progress

	always_ff @(posedge clk) begin
		if (i_valid) begin
			sum_buf[slot] <= total;
			if (i_last_group) begin              // Final value of this pixel
				o_wr_data <= total;
				o_wr_addr <= i_wr_addr;
			end
		end
	end

	// Write handshake, enable held until re, then one valid
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_wr_en <= 1'b0;
			o_wr_valid <= 1'b0;
		end else begin
			o_wr_valid <= o_wr_en & i_wr_re;
			if (i_valid && i_last_group)
				o_wr_en <= 1'b1;
			else if (i_wr_re)
				o_wr_en <= 1'b0;
		end
	end

endmodule

// File: rtl/mac_array.sv
`timescale 1ns/1ns
module mac_array #(
	parameter int LANES = 16,
	parameter int TAPS = 9
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_valid,
	input  logic                              i_first,
	input  logic                              i_last,
	input  conv_pkg::word_t [LANES-1:0]       i_data_atom,
	input  conv_pkg::word_t [LANES*TAPS-1:0]  i_wt_buf,
	input  logic [$clog2(TAPS)-1:0]           i_tap,
	output conv_pkg::word_t                   o_psum,
	output logic                              o_valid
);
	import conv_pkg::*;

	word_t [LANES-1:0] prod;                     // Stage 1
	word_t lane_sum;
	word_t lane_sum_q;                           // Stage 2
	logic [1:0] v_pipe;                          // Flags of stages 1 and 2
	logic [1:0] first_pipe;
	logic [1:0] last_pipe;

	// Products wrap to the word width
	always_ff @(posedge clk) begin
		for (int l = 0; l < LANES; l++)
			prod[l] <= i_data_atom[l] * i_wt_buf[i_tap * LANES + l];
	end

	// Lane adder tree
	always_comb begin
		lane_sum = '0;
		for (int l = 0; l < LANES; l++)
			lane_sum = lane_sum + prod[l];
	end

	always_ff @(posedge clk) begin
		lane_sum_q <= lane_sum;
		if (v_pipe[1])                           // Tap accumulator
			o_psum <= first_pipe[1] ? lane_sum_q : o_psum + lane_sum_q;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			v_pipe <= '0;
			first_pipe <= '0;
			last_pipe <= '0;
			o_valid <= 1'b0;
		end else begin
			v_pipe <= {v_pipe[0], i_valid};
			first_pipe <= {first_pipe[0], i_first};
			last_pipe <= {last_pipe[0], i_last};
			o_valid <= v_pipe[1] & last_pipe[1];  // Only the pixel's last tap
		end
	end

endmodule

// File: test/conv_engine_props.sv
`timescale 1ns/1ns
module conv_engine_props (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_start,
	input  logic                        i_done,
	input  logic                        i_data_rd,
	input  logic                        i_wt_rd,
	input  logic                        i_wr_en,
	input  logic [conv_pkg::ADDR_W-1:0] i_wr_addr,
	input  logic                        i_wr_re,
	input  logic                        i_wr_valid,
	input  conv_pkg::state_t            i_state
);
	import conv_pkg::*;

	logic started;                               // First layer has begun
	logic quiet;
	int fail_cnt = 0;                            // Failed assertions so far

	assign quiet = !i_done && !i_data_rd && !i_wt_rd && !i_wr_en && !i_wr_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			started <= 1'b0;
		else if (i_start)
			started <= 1'b1;
	end

	a_reset_quiet: assert property (@(posedge clk) rst |-> quiet)
		else begin
			fail_cnt++;
			$error("Engine outputs active while reset is held");
		end

	// Nothing moves between reset release and the first start
	a_idle_quiet: assert property (@(posedge clk) disable iff (rst) !started |-> quiet)
		else begin
			fail_cnt++;
			$error("Engine outputs active before the first start");
		end

	a_data_rd_pulse: assert property (@(posedge clk) disable iff (rst) i_data_rd |=> !i_data_rd)
		else begin
			fail_cnt++;
			$error("Data read pulse longer than one cycle");
		end

	a_wt_rd_pulse: assert property (@(posedge clk) disable iff (rst) i_wt_rd |=> !i_wt_rd)
		else begin
			fail_cnt++;
			$error("Weight read pulse longer than one cycle");
		end

	// Enable and address hold until the DMA accepts
	a_wr_hold: assert property (@(posedge clk) disable iff (rst)
		i_wr_en && !i_wr_re |=> i_wr_en && $stable(i_wr_addr))
		else begin
			fail_cnt++;
			$error("Write enable or address changed before the DMA accepted");
		end

	a_wr_valid: assert property (@(posedge clk) disable iff (rst)
		i_wr_en && i_wr_re |=> !i_wr_en && i_wr_valid)
		else begin
			fail_cnt++;
			$error("Write valid did not follow the accept by one cycle");
		end

	// Layer ends only once the write port has gone quiet
	a_idle_no_write: assert property (@(posedge clk) disable iff (rst)
		i_state == ST_IDLE |-> !i_wr_en && !i_wr_valid)
		else begin
			fail_cnt++;
			$error("Write sequence still running while the controller is idle");
		end

endmodule

bind conv_engine conv_engine_props u_props (
	.clk(clk), .rst(rst), .i_start(i_start), .i_done(o_done),
	.i_data_rd(o_data_rd_en), .i_wt_rd(o_wt_rd_en),
	.i_wr_en(o_wr_en), .i_wr_addr(o_wr_addr), .i_wr_re(i_wr_re),
	.i_wr_valid(o_wr_valid), .i_state(u_ctrl.state)
);

// File: test/tb_conv_engine.sv
`timescale 1ns/1ns
module tb_conv_engine;
	import conv_pkg::*;

	localparam int MEM_WORDS = 4096;             // DMA memory holding data and weights
	localparam int EXP_WORDS = 64;
	localparam int DATA_BASE = 0;
	localparam int WT_BASE = 2048;
	localparam int RES_BASE = 20000;             // Result region lies past the memory
	localparam logic [31:0] SEED = 32'h227d;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam int N_TESTS = 3;
	// Layer table with one column per test
	localparam int T_K [N_TESTS] = '{1, 3, 2};
	localparam int T_S [N_TESTS] = '{1, 1, 2};
	localparam int T_IC [N_TESTS] = '{8, 20, 5};
	localparam int T_OC [N_TESTS] = '{1, 1, 2};
	localparam int T_IS [N_TESTS] = '{4, 5, 6};
	localparam int T_OS [N_TESTS] = '{4, 3, 3};

	logic clk;
	logic rst;
	logic i_start;
	logic o_done;
	logic [CNT_W-1:0] i_kernel;
	logic [CNT_W-1:0] i_stride;
	logic [CH_W-1:0] i_i_channel;
	logic [CH_W-1:0] i_o_channel;
	logic [CNT_W-1:0] i_i_side;
	logic [CNT_W-1:0] i_o_side;
	logic [ADDR_W-1:0] i_data_addr;
	logic [ADDR_W-1:0] i_weight_addr;
	logic [ADDR_W-1:0] i_result_addr;
	logic o_data_rd_en;
	logic [ADDR_W-1:0] o_data_rd_addr;
	word_t i_data;
	logic i_data_we;
	logic o_wt_rd_en;
	logic [ADDR_W-1:0] o_wt_rd_addr;
	word_t i_wt;
	logic i_wt_we;
	logic o_wr_en;
	logic [ADDR_W-1:0] o_wr_addr;
	logic i_wr_re;
	logic o_wr_valid;
	word_t o_wr_data;

	word_t mem [MEM_WORDS];
	word_t exp_mem [EXP_WORDS];                  // Expected result per layout offset
	logic seen [EXP_WORDS];                      // Offsets already written
	int n_exp;
	int valid_cnt;
	int layer_base;                              // valid_cnt at layer start
	int errors = 0;
	int tests_run = 0;
	logic [31:0] lfsr_mem = SEED;
	logic [31:0] lfsr_dlat = SEED;               // One stream per DMA port
	logic [31:0] lfsr_wlat = SEED;
	logic [31:0] lfsr_wr = SEED;
	logic [ADDR_W-1:0] wr_off;
	logic in_range;

	assign wr_off = o_wr_addr - i_result_addr;
	assign in_range = wr_off < ADDR_W'(n_exp);

	conv_engine dut (.*);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], st[0]};
			st = (st >> 1) ^ (st[0] ? LFSR_TAPS : 32'h0);
		end
		return v;
	endfunction

	// Own check failures plus those of the bound property module
	function automatic int count_failures();
		return errors + dut.u_props.fail_cnt;
	endfunction

	function automatic int total_atoms();
		int sum;
		sum = 0;
		for (int t = 0; t < N_TESTS; t++)    // Groups times taps per output pixel
			sum += T_OC[t] * T_OS[t] * T_OS[t] * ((T_IC[t] + PARA - 1) / PARA) * T_K[t] * T_K[t];
		return sum;
	endfunction

	// Expected output pixel from the memory layouts with 16-bit wrap
	function automatic word_t ref_pixel(input int t, input int oc, input int y, input int x);
		word_t acc;
		int d_idx;
		int w_idx;
		acc = '0;
		for (int kr = 0; kr < T_K[t]; kr++)
			for (int kc = 0; kc < T_K[t]; kc++)
				for (int ch = 0; ch < T_IC[t]; ch++) begin
					d_idx = DATA_BASE + ((y * T_S[t] + kr) * T_IS[t] + x * T_S[t] + kc) * T_IC[t] + ch;
					w_idx = WT_BASE + ((oc * T_K[t] + kr) * T_K[t] + kc) * T_IC[t] + ch;
					acc = acc + word_t'(mem[d_idx] * mem[w_idx]);
				end
		return acc;
	endfunction

	// Words left in this channel group up to one atom
	function automatic int burst_len(input logic [ADDR_W-1:0] addr, input logic [ADDR_W-1:0] base);
		int ic;
		int ch;
		ic = int'(i_i_channel);
		ch = int'(addr - base) % ic;
		return (ic - ch > PARA) ? PARA : ic - ch;
	endfunction

	// One burst on a read port after 1 to 4 cycles
	task automatic answer_read(input logic wt_port, input logic [ADDR_W-1:0] addr);
		int len;
		int lat;
		len = burst_len(addr, wt_port ? i_weight_addr : i_data_addr);
		if (wt_port)
			lat = 1 + int'(take_bits(lfsr_wlat, 2));
		else
			lat = 1 + int'(take_bits(lfsr_dlat, 2));
		repeat (lat) @(posedge clk);
		#1;
		for (int k = 0; k < len; k++) begin
			if (wt_port) begin
				i_wt = mem[int'(addr) + k];
				i_wt_we = 1'b1;
			end else begin
				i_data = mem[int'(addr) + k];
				i_data_we = 1'b1;
			end
			@(posedge clk);
			#1;
		end
		i_wt_we = 1'b0;
		i_data_we = 1'b0;
	endtask

	task automatic run_layer(input int t, input string name);
		int errs_before;
		int os;
		errs_before = count_failures();
		os = T_OS[t];
		i_kernel = CNT_W'(T_K[t]);
		i_stride = CNT_W'(T_S[t]);
		i_i_channel = CH_W'(T_IC[t]);
		i_o_channel = CH_W'(T_OC[t]);
		i_i_side = CNT_W'(T_IS[t]);
		i_o_side = CNT_W'(os);
		i_data_addr = ADDR_W'(DATA_BASE);
		i_weight_addr = ADDR_W'(WT_BASE);
		i_result_addr = ADDR_W'(RES_BASE);
		n_exp = T_OC[t] * os * os;
		for (int oc = 0; oc < T_OC[t]; oc++)
			for (int y = 0; y < os; y++)
				for (int x = 0; x < os; x++)
					exp_mem[(oc * os + y) * os + x] = ref_pixel(t, oc, y, x);
		for (int i = 0; i < EXP_WORDS; i++)
			seen[i] = 1'b0;
		layer_base = valid_cnt;
		i_start = 1'b1;
		@(posedge clk);
		#1;
		i_start = 1'b0;
		while (!o_done) begin                    // Watchdog bounds this wait
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk);               // Count check samples the rise of done
		#1;
		tests_run++;
		$display("test %s: %0d results, %0d errors", name, valid_cnt - layer_base,
			count_failures() - errs_before);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_cnt <= 0;
		end else if (o_wr_valid) begin
			valid_cnt <= valid_cnt + 1;
			if (in_range)
				seen[wr_off] <= 1'b1;
		end
	end

	// Result checks on every write valid
	a_addr_range: assert property (@(posedge clk) disable iff (rst) o_wr_valid |-> in_range)
		else begin
			errors++;
			$display("CHECK FAILED t=%0t o_wr_addr got %h exp %h..%h", $time, o_wr_addr,
				i_result_addr, i_result_addr + ADDR_W'(n_exp - 1));
		end

	a_wr_data: assert property (@(posedge clk) disable iff (rst)
		o_wr_valid && in_range |-> o_wr_data == exp_mem[wr_off])
		else begin
			errors++;
			$display("CHECK FAILED t=%0t o_wr_data at %h got %h exp %h", $time, o_wr_addr,
				o_wr_data, exp_mem[wr_off]);
		end

	a_no_repeat: assert property (@(posedge clk) disable iff (rst)
		o_wr_valid && in_range |-> !seen[wr_off])
		else begin
			errors++;
			$display("Result address %h written more than once at %0t", o_wr_addr, $time);
		end

	// Done only once every result has gone out
	a_done_count: assert property (@(posedge clk) disable iff (rst)
		$rose(o_done) |-> valid_cnt - layer_base == n_exp)
		else begin
			errors++;
			$display("CHECK FAILED t=%0t write valid count got %0d exp %0d", $time,
				valid_cnt - layer_base, n_exp);
		end

	initial begin : data_port
		forever begin
			@(posedge clk);
			#1;
			if (!rst && o_data_rd_en)
				answer_read(1'b0, o_data_rd_addr);
		end
	end

	initial begin : weight_port
		forever begin
			@(posedge clk);
			#1;
			if (!rst && o_wt_rd_en)
				answer_read(1'b1, o_wt_rd_addr);
		end
	end

	// Accept each write after 0 to 7 cycles
	initial begin : write_port
		int delay;
		forever begin
			@(posedge clk);
			#1;
			if (!rst && o_wr_en) begin
				delay = int'(take_bits(lfsr_wr, 3));
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				i_wr_re = 1'b1;
				@(posedge clk);
				#1;
				i_wr_re = 1'b0;
			end
		end
	end

	initial begin : watchdog
		int limit;
		limit = 50 * total_atoms() + 1000;
		repeat (limit) @(posedge clk);
		$display("Timeout: layers did not finish within %0d cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		i_start = 1'b0;
		i_kernel = '0;
		i_stride = '0;
		i_i_channel = '0;
		i_o_channel = '0;
		i_i_side = '0;
		i_o_side = '0;
		i_data_addr = '0;
		i_weight_addr = '0;
		i_result_addr = '0;
		i_data = '0;
		i_data_we = 1'b0;
		i_wt = '0;
		i_wt_we = 1'b0;
		i_wr_re = 1'b0;
		n_exp = 0;
		layer_base = 0;
		for (int a = 0; a < MEM_WORDS; a++)      // Every word from its own LFSR bits
			mem[a] = word_t'(take_bits(lfsr_mem, DATA_W));
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (5) @(posedge clk);               // Idle window before the first start
		#1;
		tests_run++;
		$display("test reset_quiet: done, %0d errors", count_failures());
		run_layer(0, "k1_s1_dot");
		run_layer(1, "k3_two_groups");
		run_layer(2, "k2_s2_two_oc");
		$display("summary: %0d tests run, %0d checks failed", tests_run, count_failures());
		if (count_failures() == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
